// ==== design/pci_cfg.svh ====
`ifndef PCI_CFG_SVH
`define PCI_CFG_SVH

// ******************************
// Target address window
// ******************************

// Upper address bits [31:8] claimed by the target
`define PCI_BAR_BASE    24'hA0_0000

// ******************************
// Local memory and burst sizing
// ******************************

// SRAM words, 256 byte window
`define PCI_MEM_DEPTH   64

// Data phases accepted before disconnect with data
`define PCI_BURST_LIMIT 8

`endif

// ==== design/pci_bus_pkg.sv ====
`include "pci_cfg.svh"

package pci_bus_pkg;

   // Multiplexed address and data word
   typedef logic [31:0] pci_ad_t;

   // Command in the address phase, byte enables in data phases
   typedef logic [3:0] pci_cbe_t;

   // Completed data phases in one burst
   typedef logic [$clog2(`PCI_BURST_LIMIT + 1)-1:0] burst_cnt_t;

   // C/BE# encodings during the address phase
   typedef enum logic [3:0] {
      int_ack       = 4'b0000,
      special_cycle = 4'b0001,
      io_read       = 4'b0010,
      io_write      = 4'b0011,
      mem_read      = 4'b0110,
      mem_write     = 4'b0111,
      cfg_read      = 4'b1010,
      cfg_write     = 4'b1011,
      mem_read_mult = 4'b1100,
      dual_addr     = 4'b1101,
      mem_read_line = 4'b1110,
      mem_write_inv = 4'b1111
   } pci_cmd_e;

   // Target handshake states
   typedef enum logic [2:0] {
      idle,
      decode,
      data,
      turn_wait,
      backoff
   } tgt_state_e;

endpackage

// ==== design/local_mem_pkg.sv ====
`include "pci_cfg.svh"

package local_mem_pkg;

   // One SRAM word, same width as the bus
   typedef logic [31:0] mem_word_t;

   // Word address into the SRAM
   typedef logic [$clog2(`PCI_MEM_DEPTH)-1:0] mem_addr_t;

   // Byte lane write enables, active high
   typedef logic [3:0] mem_ben_t;

endpackage

// ==== design/pci_target_ctrl.sv ====
`timescale 1ns/1ns
`include "pci_cfg.svh"

module pci_target_ctrl (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     framen,
   input  logic                     irdyn,
   input  pci_bus_pkg::pci_ad_t     ad_in,
   input  pci_bus_pkg::pci_cbe_t    cben,
   output logic                     devseln,
   output logic                     trdyn,
   output logic                     stopn,
   output local_mem_pkg::mem_addr_t mem_addr,
   output local_mem_pkg::mem_word_t mem_wdata,
   output local_mem_pkg::mem_ben_t  mem_ben,
   output logic                     mem_we,
   output logic                     rd_phase,
   output logic                     xfer
);
   import pci_bus_pkg::*;
   import local_mem_pkg::*;

   localparam burst_cnt_t LAST_CNT = burst_cnt_t'(`PCI_BURST_LIMIT - 1);

   tgt_state_e  state_q;
   tgt_state_e  state_d;
   pci_cmd_e    cmd_q;
   logic [23:0] base_q;
   mem_addr_t   word_addr_q;
   burst_cnt_t  cnt_q;
   burst_cnt_t  cnt_nxt;
   logic        is_wr;
   logic        hit;
   logic        last_beat;

   // ******************************
   // Decode of the captured address phase
   // ******************************
   assign is_wr     = (cmd_q == mem_write);
   assign hit       = (base_q == `PCI_BAR_BASE) && (cmd_q == mem_read || cmd_q == mem_write);
   assign last_beat = (cnt_q == LAST_CNT);
   assign cnt_nxt   = cnt_q + 1'b1;

   // Phase completes when both ready lines are low
   assign xfer     = (state_q == data) && !irdyn && !trdyn;
   assign rd_phase = !is_wr && (state_q == turn_wait || state_q == data);

   // SRAM side
   assign mem_we    = xfer && is_wr;
   assign mem_wdata = ad_in;
   assign mem_ben   = ~cben;
   // Reads look one word ahead so bursts run without wait states
   assign mem_addr  = (xfer && !is_wr) ? word_addr_q + 1'b1 : word_addr_q;

   // Address phase capture and word address advance
   always_ff @(posedge clk) begin
      if (state_q == idle && !framen) begin
         base_q      <= ad_in[31:8];
         cmd_q       <= pci_cmd_e'(cben);
         word_addr_q <= mem_addr_t'(ad_in[31:2]);
      end else if (xfer) begin
         word_addr_q <= word_addr_q + 1'b1;
      end
   end

   // ******************************
   // Target state machine
   // ******************************
   always_comb begin
      state_d = state_q;
      case (state_q)
         idle: begin
            if (!framen)
               state_d = decode;
         end
         decode: begin
            // Miss or unsupported command gives master abort
            if (!hit)
               state_d = backoff;
            else if (is_wr)
               state_d = data;
            else
               state_d = turn_wait;
         end
         turn_wait: begin
            state_d = data;
         end
         data: begin
            if (xfer && framen)
               state_d = idle;
            else if (xfer && last_beat)
               state_d = backoff;
         end
         backoff: begin
            if (framen && irdyn)
               state_d = idle;
         end
         default: begin
            state_d = idle;
         end
      endcase
   end

   // Handshake outputs are registered
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= idle;
         cnt_q   <= '0;
         devseln <= 1'b1;
         trdyn   <= 1'b1;
         stopn   <= 1'b1;
      end else begin
         state_q <= state_d;
         case (state_q)
            idle: begin
               cnt_q <= '0;
            end
            decode: begin
               if (hit) begin
                  devseln <= 1'b0;
                  if (is_wr) begin
                     trdyn <= 1'b0;
                     stopn <= (cnt_q != LAST_CNT);
                  end
               end
            end
            turn_wait: begin
               trdyn <= 1'b0;
               stopn <= (cnt_q != LAST_CNT);
            end
            data: begin
               if (xfer) begin
                  cnt_q <= cnt_nxt;
                  if (framen) begin
                     devseln <= 1'b1;
                     trdyn   <= 1'b1;
                     stopn   <= 1'b1;
                  end else if (last_beat) begin
                     // Disconnect, keep devsel and stop until frame drops
                     trdyn <= 1'b1;
                  end else begin
                     stopn <= (cnt_nxt != LAST_CNT);
                  end
               end
            end
            backoff: begin
               if (framen) begin
                  devseln <= 1'b1;
                  stopn   <= 1'b1;
               end
            end
            default: begin
               trdyn <= 1'b1;
            end
         endcase
      end
   end

endmodule

// ==== design/local_sram.sv ====
`timescale 1ns/1ns
`include "pci_cfg.svh"

module local_sram #(
   parameter int DEPTH = `PCI_MEM_DEPTH
) (
   input  logic                     clk,
   input  logic                     mem_we,
   input  local_mem_pkg::mem_addr_t mem_addr,
   input  local_mem_pkg::mem_word_t mem_wdata,
   input  local_mem_pkg::mem_ben_t  mem_ben,
   output local_mem_pkg::mem_word_t mem_rdata
);
   import local_mem_pkg::*;

   localparam int AW    = $clog2(DEPTH);
   localparam int LANES = $bits(mem_ben_t);

   mem_word_t        mem [DEPTH];
   logic [AW-1:0]    idx;

   // Only the bits that index DEPTH words
   assign idx = AW'(mem_addr);

   // ******************************
   // Byte lane writes
   // ******************************
   always_ff @(posedge clk) begin
      for (int b = 0; b < LANES; b++) begin
         if (mem_we && mem_ben[b])
            mem[idx][8*b +: 8] <= mem_wdata[8*b +: 8];
      end
   end

   // Registered read, old data on a same-cycle write
   always_ff @(posedge clk) begin
      mem_rdata <= mem[idx];
   end

endmodule

// ==== design/pci_out_drive.sv ====
`timescale 1ns/1ns

module pci_out_drive (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     rd_phase,
   input  logic                     xfer,
   input  logic                     irdyn,
   input  logic                     par_in,
   input  local_mem_pkg::mem_word_t mem_rdata,
   input  pci_bus_pkg::pci_ad_t     ad_in,
   input  pci_bus_pkg::pci_cbe_t    cben,
   output pci_bus_pkg::pci_ad_t     ad_out,
   output logic                     ad_oe,
   output logic                     par_out,
   output logic                     par_oe,
   output logic                     perrn
);
   import pci_bus_pkg::*;

   pci_ad_t  wr_ad_q;
   pci_cbe_t wr_cbe_q;
   logic     chk_q;
   logic     perr_hit;

   // ******************************
   // Read data and parity
   // ******************************
   assign ad_oe  = rd_phase;
   assign ad_out = rd_phase ? pci_ad_t'(mem_rdata) : '0;

   // Parity trails the AD and C/BE it covers by one clock
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         par_oe  <= 1'b0;
         par_out <= 1'b0;
      end else begin
         par_oe  <= rd_phase;
         par_out <= ^{ad_out, cben};
      end
   end

   // ******************************
   // Write parity check
   // ******************************

   // Master write data is valid while irdy is low
   always_ff @(posedge clk) begin
      if (!irdyn && !rd_phase) begin
         wr_ad_q  <= ad_in;
         wr_cbe_q <= cben;
      end
   end

   // par_in for the last phase arrives now
   assign perr_hit = chk_q && ((^{wr_ad_q, wr_cbe_q}) != par_in);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         chk_q <= 1'b0;
         perrn <= 1'b1;
      end else begin
         chk_q <= xfer && !rd_phase;
         perrn <= !perr_hit;
      end
   end

endmodule

// ==== design/pci_arbiter.sv ====
`timescale 1ns/1ns

module pci_arbiter (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       framen,
   input  logic       irdyn,
   input  logic [1:0] reqn,
   output logic [1:0] gntn
);
   logic owner_q;
   logic gnt_vld_q;
   logic used_q;
   logic bus_idle;
   logic other;
   logic rotate;

   assign bus_idle = framen && irdyn;
   assign other    = !owner_q;

   // Hand over once the owner has had its turn, or gave up its request
   assign rotate = !reqn[other] && (used_q || !gnt_vld_q || reqn[owner_q]);

   // ******************************
   // Grant pointer
   // ******************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         owner_q   <= 1'b1;
         gnt_vld_q <= 1'b0;
         used_q    <= 1'b0;
      end else if (bus_idle) begin
         if (rotate) begin
            owner_q   <= other;
            gnt_vld_q <= 1'b1;
            used_q    <= 1'b0;
         end else if (!reqn[owner_q]) begin
            gnt_vld_q <= 1'b1;
         end
      end else if (gnt_vld_q) begin
         // Bus busy under the current grant
         used_q <= 1'b1;
      end
   end

   // One-hot low grant, parked on the owner
   always_comb begin
      if (!gnt_vld_q)
         gntn = 2'b11;
      else if (owner_q)
         gntn = 2'b01;
      else
         gntn = 2'b10;
   end

endmodule

// ==== design/pci_target_top.sv ====
`timescale 1ns/1ns

module pci_target_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  framen,
   input  logic                  irdyn,
   input  pci_bus_pkg::pci_ad_t  ad_in,
   input  pci_bus_pkg::pci_cbe_t cben,
   input  logic                  par_in,
   input  logic [1:0]            reqn,
   output logic                  devseln,
   output logic                  trdyn,
   output logic                  stopn,
   output pci_bus_pkg::pci_ad_t  ad_out,
   output logic                  ad_oe,
   output logic                  par_out,
   output logic                  par_oe,
   output logic                  perrn,
   output logic [1:0]            gntn
);
   import local_mem_pkg::*;

   mem_addr_t mem_addr;
   mem_word_t mem_wdata;
   mem_word_t mem_rdata;
   mem_ben_t  mem_ben;
   logic      mem_we;
   logic      rd_phase;
   logic      xfer;

   // ******************************
   // Target datapath
   // ******************************
   pci_target_ctrl u_pci_target_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .framen    (framen),
      .irdyn     (irdyn),
      .ad_in     (ad_in),
      .cben      (cben),
      .devseln   (devseln),
      .trdyn     (trdyn),
      .stopn     (stopn),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ben   (mem_ben),
      .mem_we    (mem_we),
      .rd_phase  (rd_phase),
      .xfer      (xfer)
   );

   local_sram u_local_sram (
      .clk       (clk),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ben   (mem_ben),
      .mem_rdata (mem_rdata)
   );

   pci_out_drive u_pci_out_drive (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_phase  (rd_phase),
      .xfer      (xfer),
      .irdyn     (irdyn),
      .par_in    (par_in),
      .mem_rdata (mem_rdata),
      .ad_in     (ad_in),
      .cben      (cben),
      .ad_out    (ad_out),
      .ad_oe     (ad_oe),
      .par_out   (par_out),
      .par_oe    (par_oe),
      .perrn     (perrn)
   );

   // Bus arbiter beside the target
   pci_arbiter u_pci_arbiter (
      .clk    (clk),
      .rst_n  (rst_n),
      .framen (framen),
      .irdyn  (irdyn),
      .reqn   (reqn),
      .gntn   (gntn)
   );

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
   parameter int PERIOD = 20
) (
   output logic clk
);

   // Free running clock, low at time zero
   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

endmodule

// ==== verification/pci_target_assert.sv ====
`timescale 1ns/1ns
`include "pci_cfg.svh"

module pci_target_assert (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  framen,
   input  pci_bus_pkg::pci_ad_t  ad_in,
   input  pci_bus_pkg::pci_cbe_t cben,
   input  logic                  devseln,
   input  logic                  trdyn,
   input  logic [1:0]            gntn
);
   logic framen_q;
   logic addr_hit;

   always_ff @(posedge clk) begin
      if (!rst_n)
         framen_q <= 1'b1;
      else
         framen_q <= framen;
   end

   // Address edge of a memory command inside the window
   assign addr_hit = !framen && framen_q && (ad_in[31:8] == `PCI_BAR_BASE)
                     && (cben == 4'b0110 || cben == 4'b0111);

   // ******************************
   // Protocol properties
   // ******************************
   devsel_timing: assert property (@(posedge clk) disable iff (!rst_n)
      addr_hit |=> devseln ##1 !devseln)
      else $error("devseln not low exactly one cycle after a hit address edge");

   trdy_needs_devsel: assert property (@(posedge clk) disable iff (!rst_n)
      !trdyn |-> !devseln)
      else $error("trdyn low while devseln is high");

   single_grant: assert property (@(posedge clk) disable iff (!rst_n)
      gntn != 2'b00)
      else $error("both grants low");

endmodule

bind pci_target_top pci_target_assert u_pci_target_assert (.*);

// ==== verification/pci_target_tb.sv ====
`timescale 1ns/1ns
`include "pci_cfg.svh"

module pci_target_tb;
   import pci_bus_pkg::*;

   localparam int          VEC_WORDS = 256;
   localparam int          LIMIT     = `PCI_BURST_LIMIT;
   localparam int          DEPTH     = `PCI_MEM_DEPTH;
   localparam logic [31:0] END_MARK  = 32'hFFFF_FFFF;

   logic        clk;
   logic        rst_n;
   logic        framen;
   logic        irdyn;
   pci_ad_t     ad_in;
   pci_cbe_t    cben;
   logic        par_in;
   logic [1:0]  reqn;
   logic        devseln;
   logic        trdyn;
   logic        stopn;
   pci_ad_t     ad_out;
   logic        ad_oe;
   logic        par_out;
   logic        par_oe;
   logic        perrn;
   logic [1:0]  gntn;

   logic [31:0] vec [VEC_WORDS];
   logic [31:0] ref_mem [DEPTH];
   logic [31:0] lfsr = 32'h5885;
   pci_ad_t     prev_ad = '0;
   pci_cbe_t    prev_cbe = '0;
   logic        prev_bad = 1'b0;
   logic        cur_bad = 1'b0;
   logic [1:0]  perr_pend = 2'b00;
   logic        par_prev = 1'b0;
   logic [1:0]  last_gnt = 2'b11;
   int          errors = 0;
   int          cycles = 0;
   int          cycle_limit = 0;

   tb_clk_gen #(.PERIOD(20)) u_tb_clk_gen (.clk(clk));

   pci_target_top u_pci_target_top (
      .clk     (clk),
      .rst_n   (rst_n),
      .framen  (framen),
      .irdyn   (irdyn),
      .ad_in   (ad_in),
      .cben    (cben),
      .par_in  (par_in),
      .reqn    (reqn),
      .devseln (devseln),
      .trdyn   (trdyn),
      .stopn   (stopn),
      .ad_out  (ad_out),
      .ad_oe   (ad_oe),
      .par_out (par_out),
      .par_oe  (par_oe),
      .perrn   (perrn),
      .gntn    (gntn)
   );

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic take_bit(output logic b);
      lfsr = lfsr_next(lfsr);
      b = lfsr[0];
   endtask

   task automatic report_fail(input string msg);
      errors++;
      $display("[FAIL] %0t ns: %s", $time, msg);
   endtask

   // One bus cycle with par_in covering the previous cycle
   task automatic drive(input logic f, input logic i, input pci_ad_t ad,
                        input pci_cbe_t be, input logic bad);
      @(posedge clk);
      #2;
      par_in   = (^{prev_ad, prev_cbe}) ^ prev_bad;
      framen   = f;
      irdyn    = i;
      ad_in    = ad;
      cben     = be;
      cur_bad  = bad;
      prev_ad  = ad;
      prev_cbe = be;
      prev_bad = bad;
   endtask

   // ******************************
   // One bus transaction from the vector list
   // ******************************
   task automatic run_txn(input int p, input int num);
      pci_cbe_t    cmd;
      pci_ad_t     addr;
      pci_cbe_t    ben;
      int          len;
      int          k;
      int          widx;
      int          errs0;
      logic        corrupt;
      logic        is_wr;
      logic        hit;
      logic        w1;
      logic        w2;
      logic        stop_seen;
      logic [31:0] word;
      string       kind;

      cmd     = vec[p][3:0];
      addr    = vec[p+1];
      len     = int'(vec[p+2]);
      ben     = vec[p+3][3:0];
      corrupt = vec[p+4][0];
      is_wr   = (cmd == 4'b0111);
      hit     = (addr[31:8] == `PCI_BAR_BASE) && (is_wr || cmd == 4'b0110);
      kind    = !hit ? "abort" : (is_wr ? "write" : "read");
      errs0   = errors;

      // Grant seen by the master before it starts
      @(negedge clk);
      if (gntn != 2'b01 && gntn != 2'b10)
         report_fail($sformatf("gntn %b is not a single low grant", gntn));
      if (num > 0 && gntn == last_gnt)
         report_fail($sformatf("grant stayed at %b between transactions", gntn));
      last_gnt = gntn;

      drive(1'b0, 1'b1, addr, cmd, 1'b0);
      if (!hit) begin
         drive(1'b1, 1'b0, '0, ben, 1'b0);
         repeat (4) begin
            @(negedge clk);
            if (!devseln)
               report_fail("devseln asserted for a master abort");
         end
      end else begin
         k         = 0;
         stop_seen = 1'b0;
         widx      = int'(addr[7:2]) % DEPTH;
         while (k < len && !stop_seen) begin
            take_bit(w1);
            take_bit(w2);
            if (!framen && w1 && w2)
               drive(1'b0, 1'b1, ad_in, ben, 1'b0);
            else
               drive(k == len - 1, 1'b0, is_wr ? vec[p+5+k] : '0, ben,
                     corrupt && is_wr && k == 0);
            @(negedge clk);
            if (!irdyn && !trdyn) begin
               word = vec[p+5+k];
               if (is_wr) begin
                  for (int b = 0; b < 4; b++) begin
                     if (!ben[b])
                        ref_mem[widx][8*b +: 8] = word[8*b +: 8];
                  end
               end else begin
                  if (ad_out !== word)
                     report_fail($sformatf("read phase %0d got %h, expected %h",
                                           k, ad_out, word));
                  if (ad_out !== ref_mem[widx])
                     report_fail($sformatf("read phase %0d got %h, reference memory %h",
                                           k, ad_out, ref_mem[widx]));
               end
               // Target drives AD and PAR only for reads
               if (ad_oe !== !is_wr || par_oe !== !is_wr)
                  report_fail($sformatf("ad_oe %b, par_oe %b on phase %0d",
                                        ad_oe, par_oe, k));
               if (!stopn != (k == LIMIT - 1))
                  report_fail($sformatf("stopn %b on phase %0d", stopn, k));
               stop_seen = !stopn;
               k++;
               widx = (widx + 1) % DEPTH;
            end
         end
      end

      // Release the bus and leave idle cycles for the arbiter
      repeat (2) drive(1'b1, 1'b1, '0, '0, 1'b0);
      $display("test %0d: %s at %h, len %0d, %0d errors", num, kind, addr, len,
               errors - errs0);
   endtask

   // ******************************
   // Parity monitors
   // ******************************
   always @(negedge clk) begin
      if (rst_n) begin
         if (perrn !== !perr_pend[1])
            report_fail($sformatf("perrn %b, expected %b", perrn, !perr_pend[1]));
         if (par_oe && par_out !== par_prev)
            report_fail($sformatf("par_out %b, expected %b", par_out, par_prev));
      end
      perr_pend = {perr_pend[0], !irdyn && !trdyn && cur_bad};
      par_prev  = ^{ad_out, cben};
   end

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial begin
      int p;
      int num;

      rst_n  = 1'b0;
      framen = 1'b1;
      irdyn  = 1'b1;
      ad_in  = '0;
      cben   = '0;
      par_in = 1'b0;
      reqn   = 2'b00;
      for (int i = 0; i < VEC_WORDS; i++)
         vec[i] = END_MARK;
      $readmemh("verification/pci_input_vectors.txt", vec);

      // Limit follows from the vector length
      p = 0;
      while (p < VEC_WORDS - 2 && vec[p] != END_MARK)
         p += 5 + int'(vec[p+2]);
      cycle_limit = p * 20 + 200;

      repeat (2) @(posedge clk);
      #2;
      // Idle levels while reset is held
      if (devseln !== 1'b1 || trdyn !== 1'b1 || stopn !== 1'b1 || perrn !== 1'b1)
         report_fail("devseln, trdyn, stopn or perrn not high in reset");
      if (ad_oe !== 1'b0 || par_oe !== 1'b0 || gntn !== 2'b11)
         report_fail("ad_oe, par_oe or gntn not at the reset level");
      rst_n = 1'b1;
      repeat (2) @(posedge clk);

      p   = 0;
      num = 0;
      while (p < VEC_WORDS - 2 && vec[p] != END_MARK) begin
         run_txn(p, num);
         p += 5 + int'(vec[p+2]);
         num++;
      end
      if (num == 0)
         report_fail("no transactions found in the vector file");

      // Drain the perrn pipeline
      repeat (4) @(posedge clk);
      $display("tests run %0d, failures %0d", num, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== verification/pci_input_vectors.txt ====
// cmd addr len ben_n corrupt, then len data words (write data or expected read data)
// all hex; cmd 7 write, 6 read, other commands are not claimed
7 a0000000 4 0 0 11111111 22222222 33333333 44444444
7 a0000004 2 5 0 aabbccdd 55667788
6 a0000000 4 0 0 11111111 aa22cc22 55337733 44444444
7 b0000000 1 0 0 00000000
3 a0000000 1 0 0 00000000
7 a0000060 2 0 0 cafe0018 cafe0019
7 a0000040 a 0 0 a0a0a010 a0a0a011 a0a0a012 a0a0a013 a0a0a014
a0a0a015 a0a0a016 a0a0a017 a0a0a018 a0a0a019
6 a0000058 4 0 0 a0a0a016 a0a0a017 cafe0018 cafe0019
7 a0000080 2 0 1 12345678 9abcdef0
6 a0000080 2 0 0 12345678 9abcdef0
6 a0000040 8 3 0 a0a0a010 a0a0a011 a0a0a012 a0a0a013 a0a0a014
a0a0a015 a0a0a016 a0a0a017
ffffffff

// ==== project.f ====
+incdir+design
design/pci_bus_pkg.sv
design/local_mem_pkg.sv
design/pci_target_ctrl.sv
design/local_sram.sv
design/pci_out_drive.sv
design/pci_arbiter.sv
design/pci_target_top.sv
verification/tb_clk_gen.sv
verification/pci_target_assert.sv
verification/pci_target_tb.sv

// ==== Makefile ====
# Verilator build and run for the PCI target testbench

VERILATOR ?= verilator
TOP       ?= pci_target_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
